// File: common/dma_defines.svh
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Datapath widths
`define DMA_ADDR_W    32
`define DMA_DATA_W    32
`define DMA_SIZE_W    24
`define DMA_COUNT_W   16
`define DMA_IP_W      3
`define DMA_FLAG_W    8

// Command table depth
`define DMA_CMD_DEPTH 8

// Bytes per word
`define DMA_ADDR_STEP 4

// Command flag bits
`define FLAG_SRC_INC          0
`define FLAG_SRC_DEC          1
`define FLAG_DEST_INC         2
`define FLAG_DEST_DEC         3
`define FLAG_SRC_RST_ON_CMD   4
`define FLAG_DEST_RST_ON_CMD  5
`define FLAG_STOP             6

`endif

// File: common/dma_pkg.sv
`default_nettype none

`include "dma_defines.svh"

package dma_pkg;

  typedef logic [`DMA_ADDR_W-1:0]  addr_t;
  typedef logic [`DMA_DATA_W-1:0]  word_t;
  typedef logic [`DMA_SIZE_W-1:0]  size_t;
  typedef logic [`DMA_COUNT_W-1:0] count_t;
  typedef logic [`DMA_IP_W-1:0]    ip_t;
  typedef logic [`DMA_FLAG_W-1:0]  flags_t;

  // Channel sequencer states
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    ISSUE,
    ACTIVE,
    END_COMMAND,
    FLUSH,
    FINISHED
  } seq_state_e;

endpackage

`default_nettype wire

// File: logic/dma_cmd_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "dma_defines.svh"

module dma_cmd_table (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 i_cmd_wr,
  input  dma_pkg::ip_t        i_cmd_index,
  input  dma_pkg::addr_t      i_cmd_src_addr,
  input  dma_pkg::addr_t      i_cmd_dest_addr,
  input  dma_pkg::count_t     i_cmd_count,
  input  dma_pkg::flags_t     i_cmd_flags,
  input  dma_pkg::ip_t        i_cmd_next,
  input  dma_pkg::ip_t        i_rd_ip,
  output dma_pkg::addr_t      o_src_addr,
  output dma_pkg::addr_t      o_dest_addr,
  output dma_pkg::count_t     o_count,
  output dma_pkg::flags_t     o_flags,
  output dma_pkg::ip_t        o_next
);

  dma_pkg::addr_t  src_mem   [`DMA_CMD_DEPTH];
  dma_pkg::addr_t  dest_mem  [`DMA_CMD_DEPTH];
  dma_pkg::count_t count_mem [`DMA_CMD_DEPTH];
  dma_pkg::flags_t flags_mem [`DMA_CMD_DEPTH];
  dma_pkg::ip_t    next_mem  [`DMA_CMD_DEPTH];

  always_ff @(posedge clk) begin
    if (i_cmd_wr) begin
      src_mem[i_cmd_index]   <= i_cmd_src_addr;
      dest_mem[i_cmd_index]  <= i_cmd_dest_addr;
      count_mem[i_cmd_index] <= i_cmd_count;
      flags_mem[i_cmd_index] <= i_cmd_flags;
      next_mem[i_cmd_index]  <= i_cmd_next;
    end
  end

  // Entry at i_rd_ip shows up one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      o_src_addr  <= '0;
      o_dest_addr <= '0;
      o_count     <= '0;
      o_flags     <= '0;
      o_next      <= '0;
    end else begin
      o_src_addr  <= src_mem[i_rd_ip];
      o_dest_addr <= dest_mem[i_rd_ip];
      o_count     <= count_mem[i_rd_ip];
      o_flags     <= flags_mem[i_rd_ip];
      o_next      <= next_mem[i_rd_ip];
    end
  end

endmodule

`default_nettype wire

// File: channel/dma_channel_seq.sv
`timescale 1ns/1ns
`default_nettype none

`include "dma_defines.svh"

module dma_channel_seq (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 i_enable,
  input  dma_pkg::ip_t        i_start_ip,
  input  dma_pkg::flags_t     i_flags,
  input  dma_pkg::ip_t        i_next,
  input  wire                 i_cmd_done,
  input  wire                 i_flush_done,
  output dma_pkg::ip_t        o_rd_ip,
  output logic                o_cmd_load,
  output logic                o_cmd_first,
  output logic                o_flush,
  output logic                o_busy,
  output logic                o_finished
);

  dma_pkg::seq_state_e state;
  dma_pkg::ip_t        ip;
  logic                first_cmd;

  assign o_rd_ip     = ip;
  assign o_cmd_load  = (state == dma_pkg::ISSUE);
  assign o_cmd_first = first_cmd;
  assign o_flush     = (state == dma_pkg::FLUSH);
  assign o_busy      = (state != dma_pkg::IDLE);
  assign o_finished  = (state == dma_pkg::FINISHED);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= dma_pkg::IDLE;
      ip        <= '0;
      first_cmd <= 1'b0;
    end else begin
      case (state)
        dma_pkg::IDLE: begin
          if (i_enable) begin
            ip        <= i_start_ip;
            first_cmd <= 1'b1;
            state     <= dma_pkg::FETCH;
          end
        end
        // Table read of the entry at ip
        dma_pkg::FETCH: begin
          if (!i_enable) begin
            state <= dma_pkg::FLUSH;
          end else begin
            state <= dma_pkg::ISSUE;
          end
        end
        dma_pkg::ISSUE: begin
          first_cmd <= 1'b0;
          if (!i_enable) begin
            state <= dma_pkg::FLUSH;
          end else begin
            state <= dma_pkg::ACTIVE;
          end
        end
        dma_pkg::ACTIVE: begin
          if (!i_enable) begin
            state <= dma_pkg::FLUSH;
          end else if (i_cmd_done) begin
            state <= dma_pkg::END_COMMAND;
          end
        end
        dma_pkg::END_COMMAND: begin
          if (!i_enable) begin
            state <= dma_pkg::FLUSH;
          end else if (i_flags[`FLAG_STOP]) begin
            state <= dma_pkg::FINISHED;
          end else begin
            // Table outputs still hold the current entry
            ip    <= i_next;
            state <= dma_pkg::FETCH;
          end
        end
        dma_pkg::FLUSH: begin
          if (i_flush_done) begin
            state <= dma_pkg::IDLE;
          end
        end
        dma_pkg::FINISHED: begin
          // Wait for enable to drop
          if (!i_enable) begin
            state <= dma_pkg::IDLE;
          end
        end
        default: begin
          state <= dma_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: channel/dma_word_mover.sv
`timescale 1ns/1ns
`default_nettype none

`include "dma_defines.svh"

module dma_word_mover (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 i_cmd_load,
  input  wire                 i_cmd_first,
  input  dma_pkg::addr_t      i_src_addr,
  input  dma_pkg::addr_t      i_dest_addr,
  input  dma_pkg::count_t     i_count,
  input  dma_pkg::flags_t     i_flags,
  input  wire                 i_flush,
  input  wire                 i_src_ready,
  input  dma_pkg::size_t      i_src_size,
  input  dma_pkg::word_t      i_src_data,
  input  wire  [1:0]          i_snk_ready,
  input  dma_pkg::size_t      i_snk_size,
  output logic                o_cmd_done,
  output logic                o_flush_done,
  output logic                o_src_activate,
  output logic                o_src_strobe,
  output dma_pkg::addr_t      o_src_address,
  output logic [1:0]          o_snk_activate,
  output logic                o_snk_strobe,
  output dma_pkg::word_t      o_snk_data,
  output dma_pkg::addr_t      o_snk_address
);

  logic            cmd_busy;
  dma_pkg::count_t remaining;
  dma_pkg::size_t  src_cnt;
  dma_pkg::size_t  snk_cnt;
  dma_pkg::addr_t  cur_src;
  dma_pkg::addr_t  cur_dest;
  dma_pkg::flags_t flags_q;
  logic            copy_en;

  function automatic dma_pkg::addr_t step_addr(input dma_pkg::addr_t addr,
                                               input logic inc,
                                               input logic dec);
    dma_pkg::addr_t step;
    step = dma_pkg::addr_t'(`DMA_ADDR_STEP);
    if (inc) begin
      return addr + step;
    end else if (dec) begin
      return addr - step;
    end
    return addr;
  endfunction

  // Both buffers open with room and no strobe in the last cycle
  assign copy_en = o_src_activate && (o_snk_activate != 2'b00) &&
                   (src_cnt < i_src_size) && (snk_cnt < i_snk_size) && !o_src_strobe;

  assign o_flush_done = !o_src_activate && (o_snk_activate == 2'b00);

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_busy       <= 1'b0;
      remaining      <= '0;
      src_cnt        <= '0;
      snk_cnt        <= '0;
      o_cmd_done     <= 1'b0;
      o_src_activate <= 1'b0;
      o_src_strobe   <= 1'b0;
      o_snk_activate <= 2'b00;
      o_snk_strobe   <= 1'b0;
    end else begin
      o_cmd_done   <= 1'b0;
      o_src_strobe <= 1'b0;
      o_snk_strobe <= 1'b0;
      if (i_flush) begin
        cmd_busy <= 1'b0;
        // Drain the source buffer
        if (o_src_activate && (src_cnt < i_src_size)) begin
          o_src_strobe <= 1'b1;
          src_cnt      <= src_cnt + 1'b1;
        end else begin
          o_src_activate <= 1'b0;
        end
        // Pad the sink buffer with zeros
        if ((o_snk_activate != 2'b00) && (snk_cnt < i_snk_size)) begin
          o_snk_strobe <= 1'b1;
          o_snk_data   <= '0;
          snk_cnt      <= snk_cnt + 1'b1;
        end else begin
          o_snk_activate <= 2'b00;
        end
      end else if (i_cmd_load) begin
        cmd_busy  <= 1'b1;
        remaining <= i_count;
        flags_q   <= i_flags;
        if (i_cmd_first || i_flags[`FLAG_SRC_RST_ON_CMD]) begin
          cur_src <= i_src_addr;
        end
        if (i_cmd_first || i_flags[`FLAG_DEST_RST_ON_CMD]) begin
          cur_dest <= i_dest_addr;
        end
      end else if (cmd_busy) begin
        if (remaining == '0) begin
          // Sink buffer goes back at command end
          o_cmd_done     <= 1'b1;
          cmd_busy       <= 1'b0;
          o_snk_activate <= 2'b00;
        end else if (copy_en) begin
          o_snk_data   <= i_src_data;
          o_src_strobe <= 1'b1;
          o_snk_strobe <= 1'b1;
          src_cnt      <= src_cnt + 1'b1;
          snk_cnt      <= snk_cnt + 1'b1;
          remaining    <= remaining - 1'b1;
          cur_src      <= step_addr(cur_src, flags_q[`FLAG_SRC_INC], flags_q[`FLAG_SRC_DEC]);
          cur_dest     <= step_addr(cur_dest, flags_q[`FLAG_DEST_INC],
                                    flags_q[`FLAG_DEST_DEC]);
        end else begin
          if (!o_src_activate && i_src_ready) begin
            o_src_activate <= 1'b1;
            src_cnt        <= '0;
            o_src_address  <= cur_src;
          end else if (o_src_activate && (src_cnt >= i_src_size)) begin
            o_src_activate <= 1'b0;
          end
          if ((o_snk_activate == 2'b00) && (i_snk_ready != 2'b00)) begin
            // Buffer 0 first
            o_snk_activate <= i_snk_ready[0] ? 2'b01 : 2'b10;
            snk_cnt        <= '0;
            o_snk_address  <= cur_dest;
          end else if ((o_snk_activate != 2'b00) && (snk_cnt >= i_snk_size)) begin
            o_snk_activate <= 2'b00;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/dma_top.sv
`timescale 1ns/1ns
`default_nettype none

module dma_top (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 i_enable,
  input  dma_pkg::ip_t        i_start_ip,
  input  wire                 i_cmd_wr,
  input  dma_pkg::ip_t        i_cmd_index,
  input  dma_pkg::addr_t      i_cmd_src_addr,
  input  dma_pkg::addr_t      i_cmd_dest_addr,
  input  dma_pkg::count_t     i_cmd_count,
  input  dma_pkg::flags_t     i_cmd_flags,
  input  dma_pkg::ip_t        i_cmd_next,
  input  wire                 i_src_ready,
  input  dma_pkg::size_t      i_src_size,
  input  dma_pkg::word_t      i_src_data,
  input  wire  [1:0]          i_snk_ready,
  input  dma_pkg::size_t      i_snk_size,
  output logic                o_busy,
  output logic                o_finished,
  output logic                o_src_activate,
  output logic                o_src_strobe,
  output dma_pkg::addr_t      o_src_address,
  output logic [1:0]          o_snk_activate,
  output logic                o_snk_strobe,
  output dma_pkg::word_t      o_snk_data,
  output dma_pkg::addr_t      o_snk_address
);

  dma_pkg::ip_t    rd_ip;
  dma_pkg::addr_t  tbl_src_addr;
  dma_pkg::addr_t  tbl_dest_addr;
  dma_pkg::count_t tbl_count;
  dma_pkg::flags_t tbl_flags;
  dma_pkg::ip_t    tbl_next;
  logic            cmd_load;
  logic            cmd_first;
  logic            cmd_done;
  logic            flush;
  logic            flush_done;

  dma_cmd_table u_cmd_table (
    .clk             (clk),
    .rst             (rst),
    .i_cmd_wr        (i_cmd_wr),
    .i_cmd_index     (i_cmd_index),
    .i_cmd_src_addr  (i_cmd_src_addr),
    .i_cmd_dest_addr (i_cmd_dest_addr),
    .i_cmd_count     (i_cmd_count),
    .i_cmd_flags     (i_cmd_flags),
    .i_cmd_next      (i_cmd_next),
    .i_rd_ip         (rd_ip),
    .o_src_addr      (tbl_src_addr),
    .o_dest_addr     (tbl_dest_addr),
    .o_count         (tbl_count),
    .o_flags         (tbl_flags),
    .o_next          (tbl_next)
  );

  dma_channel_seq u_channel_seq (
    .clk          (clk),
    .rst          (rst),
    .i_enable     (i_enable),
    .i_start_ip   (i_start_ip),
    .i_flags      (tbl_flags),
    .i_next       (tbl_next),
    .i_cmd_done   (cmd_done),
    .i_flush_done (flush_done),
    .o_rd_ip      (rd_ip),
    .o_cmd_load   (cmd_load),
    .o_cmd_first  (cmd_first),
    .o_flush      (flush),
    .o_busy       (o_busy),
    .o_finished   (o_finished)
  );

  dma_word_mover u_word_mover (
    .clk            (clk),
    .rst            (rst),
    .i_cmd_load     (cmd_load),
    .i_cmd_first    (cmd_first),
    .i_src_addr     (tbl_src_addr),
    .i_dest_addr    (tbl_dest_addr),
    .i_count        (tbl_count),
    .i_flags        (tbl_flags),
    .i_flush        (flush),
    .i_src_ready    (i_src_ready),
    .i_src_size     (i_src_size),
    .i_src_data     (i_src_data),
    .i_snk_ready    (i_snk_ready),
    .i_snk_size     (i_snk_size),
    .o_cmd_done     (cmd_done),
    .o_flush_done   (flush_done),
    .o_src_activate (o_src_activate),
    .o_src_strobe   (o_src_strobe),
    .o_src_address  (o_src_address),
    .o_snk_activate (o_snk_activate),
    .o_snk_strobe   (o_snk_strobe),
    .o_snk_data     (o_snk_data),
    .o_snk_address  (o_snk_address)
  );

endmodule

`default_nettype wire

// File: tests/tb_dma.sv
`timescale 1ns/1ns
`default_nettype none

`include "dma_defines.svh"

module tb_dma;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int WAIT_LIMIT   = 500;
  // Word counts of the five tests with the reset test as one
  localparam int TEST_LENGTH_SUM = 1 + 5 + 10 + 7 + 20;
  localparam int WATCHDOG_CYCLES = TEST_LENGTH_SUM * 200;

  logic            clk;
  logic            rst;
  logic            i_enable;
  dma_pkg::ip_t    i_start_ip;
  logic            i_cmd_wr;
  dma_pkg::ip_t    i_cmd_index;
  dma_pkg::addr_t  i_cmd_src_addr;
  dma_pkg::addr_t  i_cmd_dest_addr;
  dma_pkg::count_t i_cmd_count;
  dma_pkg::flags_t i_cmd_flags;
  dma_pkg::ip_t    i_cmd_next;
  logic            i_src_ready;
  dma_pkg::size_t  i_src_size;
  dma_pkg::word_t  i_src_data;
  logic [1:0]      i_snk_ready;
  dma_pkg::size_t  i_snk_size;
  logic            o_busy;
  logic            o_finished;
  logic            o_src_activate;
  logic            o_src_strobe;
  dma_pkg::addr_t  o_src_address;
  logic [1:0]      o_snk_activate;
  logic            o_snk_strobe;
  dma_pkg::word_t  o_snk_data;
  dma_pkg::addr_t  o_snk_address;

  // FIFO models and what they saw
  dma_pkg::word_t src_q[$];
  dma_pkg::word_t exp_q[$];
  dma_pkg::word_t snk_data_q[$];
  int             snk_buf_q[$];
  dma_pkg::addr_t src_act_addr[$];
  int             src_act_words[$];
  dma_pkg::addr_t snk_act_addr[$];
  int             snk_act_words[$];
  logic           src_act_q;
  logic           snk_act_q;
  logic           finished_seen;

  int errors;
  int checks;
  int tests_run;

  dma_top i_dma_top (
    .clk             (clk),
    .rst             (rst),
    .i_enable        (i_enable),
    .i_start_ip      (i_start_ip),
    .i_cmd_wr        (i_cmd_wr),
    .i_cmd_index     (i_cmd_index),
    .i_cmd_src_addr  (i_cmd_src_addr),
    .i_cmd_dest_addr (i_cmd_dest_addr),
    .i_cmd_count     (i_cmd_count),
    .i_cmd_flags     (i_cmd_flags),
    .i_cmd_next      (i_cmd_next),
    .i_src_ready     (i_src_ready),
    .i_src_size      (i_src_size),
    .i_src_data      (i_src_data),
    .i_snk_ready     (i_snk_ready),
    .i_snk_size      (i_snk_size),
    .o_busy          (o_busy),
    .o_finished      (o_finished),
    .o_src_activate  (o_src_activate),
    .o_src_strobe    (o_src_strobe),
    .o_src_address   (o_src_address),
    .o_snk_activate  (o_snk_activate),
    .o_snk_strobe    (o_snk_strobe),
    .o_snk_data      (o_snk_data),
    .o_snk_address   (o_snk_address)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Show-ahead source that consumes one word per strobe
  always @(posedge clk) begin
    if (o_src_strobe && (src_q.size() > 0)) begin
      src_q.delete(0);
    end
    i_src_data <= (src_q.size() > 0) ? src_q[0] : '0;
  end

  // Records buffer activations and sink writes
  always @(posedge clk) begin
    if (o_src_activate && !src_act_q) begin
      src_act_addr.push_back(o_src_address);
      src_act_words.push_back(0);
    end
    if (o_src_strobe && (src_act_words.size() > 0)) begin
      src_act_words[src_act_words.size() - 1] += 1;
    end
    if ((o_snk_activate != 2'b00) && !snk_act_q) begin
      snk_act_addr.push_back(o_snk_address);
      snk_act_words.push_back(0);
    end
    if (o_snk_strobe) begin
      snk_data_q.push_back(o_snk_data);
      snk_buf_q.push_back(o_snk_activate[1] ? 1 : 0);
      if (snk_act_words.size() > 0) begin
        snk_act_words[snk_act_words.size() - 1] += 1;
      end
    end
    src_act_q = o_src_activate;
    snk_act_q = (o_snk_activate != 2'b00);
    if (o_finished) begin
      finished_seen = 1'b1;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("%s", msg);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_start);
    tests_run++;
    $display("Test %-18s %s (%0d errors)", name,
             (errors == errs_start) ? "ok" : "FAILED", errors - errs_start);
  endtask

  task automatic reset_dut;
    src_q.delete();
    exp_q.delete();
    snk_data_q.delete();
    snk_buf_q.delete();
    src_act_addr.delete();
    src_act_words.delete();
    snk_act_addr.delete();
    snk_act_words.delete();
    finished_seen = 1'b0;
    @(posedge clk);
    rst      <= 1'b1;
    i_enable <= 1'b0;
    i_cmd_wr <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic configure_fifos(input dma_pkg::size_t src_size,
                                 input dma_pkg::size_t snk_size, input logic [1:0] snk_ready);
    @(posedge clk);
    i_src_ready <= 1'b1;
    i_src_size  <= src_size;
    i_snk_size  <= snk_size;
    i_snk_ready <= snk_ready;
  endtask

  task automatic write_cmd(input dma_pkg::ip_t index, input dma_pkg::addr_t src,
                           input dma_pkg::addr_t dest, input dma_pkg::count_t count,
                           input dma_pkg::flags_t flags, input dma_pkg::ip_t next);
    @(posedge clk);
    i_cmd_wr        <= 1'b1;
    i_cmd_index     <= index;
    i_cmd_src_addr  <= src;
    i_cmd_dest_addr <= dest;
    i_cmd_count     <= count;
    i_cmd_flags     <= flags;
    i_cmd_next      <= next;
    @(posedge clk);
    i_cmd_wr <= 1'b0;
  endtask

  task automatic load_source(input int n);
    dma_pkg::word_t w;
    for (int i = 0; i < n; i++) begin
      w = $urandom();
      src_q.push_back(w);
      exp_q.push_back(w);
    end
  endtask

  task automatic start_run(input dma_pkg::ip_t ip);
    @(posedge clk);
    i_start_ip <= ip;
    i_enable   <= 1'b1;
  endtask

  task automatic wait_finished(output logic seen);
    int n;
    n    = 0;
    seen = 1'b0;
    while (!seen && (n < WAIT_LIMIT)) begin
      @(posedge clk);
      n++;
      seen = o_finished;
    end
  endtask

  task automatic stop_run;
    int n;
    @(posedge clk);
    i_enable <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (o_busy && (n < WAIT_LIMIT));
    expect_true(!o_busy, "o_busy stayed high after enable dropped");
  endtask

  task automatic verify_activation(input logic sink, input int idx,
                                   input dma_pkg::addr_t addr, input int words);
    if (sink && (idx < snk_act_addr.size())) begin
      expect_equal($sformatf("o_snk_address[%0d]", idx), snk_act_addr[idx], addr);
      expect_equal($sformatf("sink buffer %0d words", idx), snk_act_words[idx], words);
    end else if (!sink && (idx < src_act_addr.size())) begin
      expect_equal($sformatf("o_src_address[%0d]", idx), src_act_addr[idx], addr);
      expect_equal($sformatf("source buffer %0d words", idx), src_act_words[idx], words);
    end else begin
      expect_true(1'b0, $sformatf("Buffer activation %0d never happened on the %s side",
                                  idx, sink ? "sink" : "source"));
    end
  endtask

  // Full buffers of size words followed by the remainder
  task automatic verify_buffers(input logic sink, input dma_pkg::addr_t base,
                                input int step, input int size, input int total);
    int             n;
    int             left;
    dma_pkg::addr_t addr;
    n = (total + size - 1) / size;
    if (sink) begin
      expect_equal("sink activations", snk_act_addr.size(), n);
    end else begin
      expect_equal("source activations", src_act_addr.size(), n);
    end
    for (int i = 0; i < n; i++) begin
      left = total - i * size;
      addr = base + dma_pkg::addr_t'(step * size * i);
      verify_activation(sink, i, addr, (left < size) ? left : size);
    end
  endtask

  task automatic compare_sink_words(input int n, input int buf_sel);
    expect_equal("sink word count", snk_data_q.size(), n);
    for (int i = 0; (i < n) && (i < snk_data_q.size()); i++) begin
      expect_equal($sformatf("o_snk_data[%0d]", i), snk_data_q[i], exp_q[i]);
      expect_equal($sformatf("sink buffer of word %0d", i), snk_buf_q[i], buf_sel);
    end
  endtask

  task automatic reset_state;
    int errs_start;
    errs_start = errors;
    reset_dut();
    @(posedge clk);
    expect_equal("o_busy", o_busy, 0);
    expect_equal("o_finished", o_finished, 0);
    expect_equal("o_src_activate", o_src_activate, 0);
    expect_equal("o_src_strobe", o_src_strobe, 0);
    expect_equal("o_snk_activate", o_snk_activate, 0);
    expect_equal("o_snk_strobe", o_snk_strobe, 0);
    report_test("reset state", errs_start);
  endtask

  task automatic single_command;
    int   errs_start;
    logic seen;
    errs_start = errors;
    reset_dut();
    configure_fifos(16, 16, 2'b01);
    write_cmd(0, 32'h0000_1000, 32'h0000_2000, 5,
              (1 << `FLAG_SRC_INC) | (1 << `FLAG_DEST_INC) | (1 << `FLAG_STOP), 0);
    load_source(5);
    start_run(0);
    wait_finished(seen);
    expect_true(seen, "o_finished never rose on the single command");
    // Finished holds while enable stays high
    @(posedge clk);
    expect_equal("o_finished", o_finished, 1);
    compare_sink_words(5, 0);
    verify_activation(1'b0, 0, 32'h0000_1000, 5);
    verify_activation(1'b1, 0, 32'h0000_2000, 5);
    stop_run();
    expect_equal("o_finished", o_finished, 0);
    report_test("single command", errs_start);
  endtask

  task automatic buffer_boundaries;
    int   errs_start;
    logic seen;
    errs_start = errors;
    reset_dut();
    // Buffer 0 not ready, so every sink buffer is buffer 1
    configure_fifos(4, 3, 2'b10);
    write_cmd(1, 32'h0000_4000, 32'h0000_6000, 10,
              (1 << `FLAG_SRC_INC) | (1 << `FLAG_DEST_INC) | (1 << `FLAG_STOP), 0);
    load_source(10);
    start_run(1);
    wait_finished(seen);
    expect_true(seen, "o_finished never rose with small buffers");
    compare_sink_words(10, 1);
    verify_buffers(1'b0, 32'h0000_4000, 4, 4, 10);
    verify_buffers(1'b1, 32'h0000_6000, 4, 3, 10);
    stop_run();
    report_test("buffer boundaries", errs_start);
  endtask

  task automatic chained_commands;
    int   errs_start;
    logic seen;
    errs_start = errors;
    reset_dut();
    configure_fifos(3, 16, 2'b11);
    write_cmd(2, 32'h0000_8000, 32'h0000_3000, 3,
              (1 << `FLAG_SRC_DEC) | (1 << `FLAG_DEST_INC), 5);
    // Neither address reloads here
    write_cmd(5, 32'h0000_9000, 32'h0000_5000, 2,
              (1 << `FLAG_SRC_DEC) | (1 << `FLAG_DEST_INC), 6);
    write_cmd(6, 32'h0000_9100, 32'h0000_A000, 2,
              (1 << `FLAG_SRC_DEC) | (1 << `FLAG_DEST_INC) |
              (1 << `FLAG_DEST_RST_ON_CMD) | (1 << `FLAG_STOP), 0);
    load_source(7);
    start_run(2);
    wait_finished(seen);
    expect_true(seen, "o_finished never rose on the command chain");
    compare_sink_words(7, 0);
    verify_buffers(1'b0, 32'h0000_8000, -4, 3, 7);
    expect_equal("sink activations", snk_act_addr.size(), 3);
    verify_activation(1'b1, 0, 32'h0000_3000, 3);
    verify_activation(1'b1, 1, 32'h0000_3000 + 3 * 4, 2);
    verify_activation(1'b1, 2, 32'h0000_A000, 2);
    stop_run();
    report_test("chained commands", errs_start);
  endtask

  task automatic flush_mid_command;
    int errs_start;
    int n;
    int copied;
    int k;
    errs_start = errors;
    reset_dut();
    configure_fifos(6, 5, 2'b01);
    write_cmd(7, 32'h0000_C000, 32'h0000_D000, 20,
              (1 << `FLAG_SRC_INC) | (1 << `FLAG_DEST_INC), 7);
    load_source(20);
    start_run(7);
    n      = 0;
    copied = 0;
    while ((copied < 2) && (n < WAIT_LIMIT)) begin
      @(posedge clk);
      n++;
      if (o_snk_strobe) begin
        copied++;
      end
    end
    expect_true(copied >= 2, "No words were copied before the flush");
    stop_run();
    expect_true(!finished_seen, "o_finished rose during a flushed run");
    expect_equal("o_src_activate", o_src_activate, 0);
    expect_equal("o_snk_activate", o_snk_activate, 0);
    expect_equal("source activations", src_act_addr.size(), 1);
    expect_equal("sink activations", snk_act_addr.size(), 1);
    verify_activation(1'b0, 0, 32'h0000_C000, 6);
    verify_activation(1'b1, 0, 32'h0000_D000, 5);
    // Copied words come first and zero padding after
    k = 0;
    while ((k < snk_data_q.size()) && (k < exp_q.size()) && (snk_data_q[k] == exp_q[k])) begin
      k++;
    end
    expect_true(k >= 2, "Sink lost copied words before the padding");
    for (int i = k; i < snk_data_q.size(); i++) begin
      expect_equal($sformatf("o_snk_data[%0d]", i), snk_data_q[i], 0);
    end
    expect_equal("sink word count", snk_data_q.size(), 5);
    report_test("flush", errs_start);
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    void'($urandom(14));
    rst             = 1'b1;
    i_enable        = 1'b0;
    i_start_ip      = '0;
    i_cmd_wr        = 1'b0;
    i_cmd_index     = '0;
    i_cmd_src_addr  = '0;
    i_cmd_dest_addr = '0;
    i_cmd_count     = '0;
    i_cmd_flags     = '0;
    i_cmd_next      = '0;
    i_src_ready     = 1'b0;
    i_src_size      = '0;
    i_src_data      = '0;
    i_snk_ready     = 2'b00;
    i_snk_size      = '0;
    src_act_q       = 1'b0;
    snk_act_q       = 1'b0;
    finished_seen   = 1'b0;

    reset_state();
    single_command();
    buffer_boundaries();
    chained_commands();
    flush_mid_command();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
common/dma_pkg.sv
logic/dma_cmd_table.sv
channel/dma_channel_seq.sv
channel/dma_word_mover.sv
logic/dma_top.sv
tests/tb_dma.sv

// File: Bender.yml
package:
  name: dma_word_mover

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/dma_pkg.sv
      - logic/dma_cmd_table.sv
      - channel/dma_channel_seq.sv
      - channel/dma_word_mover.sv
      - logic/dma_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_dma.sv
